//--- include/itlb_params.svh
// itlb parameters: geometry, field widths, pte bit positions and memory map
`ifndef ITLB_PARAMS_SVH
`define ITLB_PARAMS_SVH

// ----------------------------
// widths and geometry
`define ITLB_VPN_WIDTH      20
`define ITLB_PPN_WIDTH      22
`define ITLB_ASID_WIDTH     9
`define ITLB_PTE_WIDTH      32
`define ITLB_SETS           4
`define ITLB_WAYS           4
`define ITLB_INDEX_WIDTH    2
`define ITLB_WAY_WIDTH      2

// exec mode code for user mode
`define ITLB_U_MODE         2'b00

// ----------------------------
// pte bits
`define ITLB_PTE_V          0
`define ITLB_PTE_R          1
`define ITLB_PTE_W          2
`define ITLB_PTE_X          3
`define ITLB_PTE_U          4
`define ITLB_PTE_G          5
`define ITLB_PTE_A          6
`define ITLB_PTE_D          7
`define ITLB_PTE_PPN_LSB    10

// stored entry, msb first: valid, asid, vpn, pte, access fault
`define ITLB_ENTRY_AF       0
`define ITLB_ENTRY_PTE_LSB  1
`define ITLB_ENTRY_VPN_LSB  33
`define ITLB_ENTRY_ASID_LSB 53
`define ITLB_ENTRY_VALID    62

// ----------------------------
// memory map, inclusive ppn ranges
`define ITLB_DRAM_PPN_LO    22'h380000
`define ITLB_DRAM_PPN_HI    22'h3BFFFF
`define ITLB_ROM_PPN_LO     22'h000010
`define ITLB_ROM_PPN_HI     22'h00001F

`endif

//--- source/itlb_addr_pkg.sv
// itlb address types: asid, page numbers, privilege mode and raw pte
`include "itlb_params.svh"

package itlb_addr_pkg;

    // address-space id
    typedef logic [`ITLB_ASID_WIDTH-1:0] asid_t;

    // virtual and physical page numbers, 4 KB pages
    typedef logic [`ITLB_VPN_WIDTH-1:0] vpn_t;
    typedef logic [`ITLB_PPN_WIDTH-1:0] ppn_t;

    // privilege mode of the fetch
    typedef logic [1:0] exec_mode_t;

    // pte as delivered by the l2 tlb
    typedef logic [`ITLB_PTE_WIDTH-1:0] pte_t;

endpackage

//--- source/itlb_entry_pkg.sv
// itlb storage types: set and way numbers, stored entries, replacement and miss state
`include "itlb_params.svh"

package itlb_entry_pkg;

    // set and way selection
    typedef logic [`ITLB_INDEX_WIDTH-1:0] index_t;
    typedef logic [`ITLB_WAY_WIDTH-1:0]   way_t;
    typedef logic [`ITLB_WAYS-1:0]        way_mask_t;

    // tree bits, one per inner node
    typedef logic [`ITLB_WAYS-2:0] plru_t;

    // one way: valid, asid, vpn, pte, access fault
    typedef logic [`ITLB_ENTRY_VALID:0] entry_t;

    // blocking miss handling
    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_REQ,
        MISS_WAIT,
        MISS_FILL
    } miss_state_t;

endpackage

//--- source/itlb_array.sv
// itlb array: per-set entries and tree bits, single-way write, registered set read
`timescale 1ns/1ns
`include "itlb_params.svh"

module itlb_array (
    input  logic                                    CLK,
    input  logic                                    nRST,
    // read port
    input  logic                                    read_en,
    input  itlb_entry_pkg::index_t                  read_index,
    output itlb_entry_pkg::entry_t [`ITLB_WAYS-1:0] read_entries,
    output itlb_entry_pkg::plru_t                   read_plru,
    // write port
    input  logic                                    write_en,
    input  itlb_entry_pkg::index_t                  write_index,
    input  itlb_entry_pkg::way_t                    write_way,
    input  itlb_entry_pkg::entry_t                  write_entry,
    input  logic                                    plru_write_en,
    input  itlb_entry_pkg::plru_t                   plru_write
);
    import itlb_entry_pkg::*;

    way_mask_t               valid_mem [`ITLB_SETS];
    plru_t                   plru_mem  [`ITLB_SETS];
    entry_t [`ITLB_WAYS-1:0] entry_mem [`ITLB_SETS];
    entry_t [`ITLB_WAYS-1:0] read_next;

    // valid and tree bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            for (int s = 0; s < `ITLB_SETS; s++) begin
                valid_mem[s] <= '0;
                plru_mem[s] <= '0;
            end
        end else begin
            if (write_en) begin
                valid_mem[write_index][write_way] <= write_entry[`ITLB_ENTRY_VALID];
            end
            if (plru_write_en) begin
                plru_mem[write_index] <= plru_write;
            end
        end
    end

    // entry payload
    always_ff @(posedge CLK) begin
        if (write_en) begin
            entry_mem[write_index][write_way] <= write_entry;
        end
    end

    // valid bits come from the reset copy
    always_comb begin
        read_next = entry_mem[read_index];
        for (int w = 0; w < `ITLB_WAYS; w++) begin
            read_next[w][`ITLB_ENTRY_VALID] = valid_mem[read_index][w];
        end
    end

    // read register, old data on a same-edge write
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            read_entries <= '0;
            read_plru <= '0;
        end else if (read_en) begin
            read_entries <= read_next;
            read_plru <= plru_mem[read_index];
        end
    end

endmodule

//--- source/itlb_way_select.sv
// itlb way select: hit compare, victim choice and tree pseudo-lru update
`timescale 1ns/1ns
`include "itlb_params.svh"

module itlb_way_select (
    input  logic                                    stage_valid,
    input  itlb_addr_pkg::asid_t                    lookup_asid,
    input  itlb_addr_pkg::vpn_t                     lookup_vpn,
    input  itlb_entry_pkg::entry_t [`ITLB_WAYS-1:0] entries,
    input  itlb_entry_pkg::plru_t                   plru_in,
    input  logic                                    fill,
    output logic                                    hit,
    output itlb_entry_pkg::way_t                    hit_way,
    output itlb_entry_pkg::way_t                    victim_way,
    output logic                                    victim_valid,
    output itlb_entry_pkg::plru_t                   plru_out,
    output logic                                    plru_update
);
    import itlb_entry_pkg::*;

    way_mask_t valid_mask;
    way_mask_t hit_mask;
    way_t      invalid_way;
    way_t      plru_way;
    way_t      touch_way;

    // scan downward so the lowest way wins
    always_comb begin
        hit_way = '0;
        invalid_way = '0;
        for (int w = `ITLB_WAYS-1; w >= 0; w--) begin
            valid_mask[w] = entries[w][`ITLB_ENTRY_VALID];
            hit_mask[w] = valid_mask[w]
                & (entries[w][`ITLB_ENTRY_ASID_LSB +: `ITLB_ASID_WIDTH] == lookup_asid)
                & (entries[w][`ITLB_ENTRY_VPN_LSB +: `ITLB_VPN_WIDTH] == lookup_vpn);
            if (~valid_mask[w]) begin
                invalid_way = way_t'(w);
            end
            if (hit_mask[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // bit 0 picks the half, bit 1 or bit 2 the way inside it
    assign plru_way = {plru_in[0], plru_in[0] ? plru_in[2] : plru_in[1]};

    assign hit = |hit_mask;
    assign victim_valid = &valid_mask;
    assign victim_way = victim_valid ? plru_way : invalid_way;

    // fills touch the victim, lookups the hitting way
    assign touch_way = fill ? victim_way : hit_way;
    assign plru_update = fill | (stage_valid & hit);

    // point every node on the path away from the touched way
    always_comb begin
        plru_out = plru_in;
        plru_out[0] = ~touch_way[1];
        if (touch_way[1]) begin
            plru_out[2] = ~touch_way[0];
        end else begin
            plru_out[1] = ~touch_way[0];
        end
    end

endmodule

//--- source/itlb_fault_check.sv
// itlb fault check: response ppn, page faults from pte bits, memory-map access check
`timescale 1ns/1ns
`include "itlb_params.svh"

module itlb_fault_check (
    input  logic                       virtual_mode,
    input  itlb_addr_pkg::exec_mode_t  exec_mode,
    input  itlb_addr_pkg::vpn_t        lookup_vpn,
    input  itlb_entry_pkg::entry_t     hit_entry,
    input  itlb_addr_pkg::pte_t        fill_pte,
    output itlb_addr_pkg::ppn_t        ppn,
    output logic                       page_fault,
    output logic                       access_fault,
    output logic                       fill_pma_fault
);
    import itlb_addr_pkg::*;

    pte_t hit_pte;
    ppn_t bare_ppn;

    // page lies in dram or rom
    function automatic logic in_mem_map(ppn_t page);
        in_mem_map = (page >= `ITLB_DRAM_PPN_LO && page <= `ITLB_DRAM_PPN_HI)
            || (page >= `ITLB_ROM_PPN_LO && page <= `ITLB_ROM_PPN_HI);
    endfunction

    assign hit_pte = hit_entry[`ITLB_ENTRY_PTE_LSB +: `ITLB_PTE_WIDTH];

    // bare metal: vpn sign-extended
    assign bare_ppn = {{(`ITLB_PPN_WIDTH-`ITLB_VPN_WIDTH){lookup_vpn[`ITLB_VPN_WIDTH-1]}},
        lookup_vpn};

    always_comb begin
        if (virtual_mode) begin
            ppn = hit_pte[`ITLB_PTE_PPN_LSB +: `ITLB_PPN_WIDTH];
            page_fault = ~hit_pte[`ITLB_PTE_V]
                | ~hit_pte[`ITLB_PTE_X]
                | (hit_pte[`ITLB_PTE_W] & ~hit_pte[`ITLB_PTE_R])
                | ((exec_mode == `ITLB_U_MODE) & ~hit_pte[`ITLB_PTE_U]);
            // l2 fault and pma result were merged at fill
            access_fault = hit_entry[`ITLB_ENTRY_AF];
        end else begin
            ppn = bare_ppn;
            page_fault = 1'b0;
            access_fault = ~in_mem_map(bare_ppn);
        end
    end

    assign fill_pma_fault = ~in_mem_map(fill_pte[`ITLB_PTE_PPN_LSB +: `ITLB_PPN_WIDTH]);

endmodule

//--- source/itlb_miss_ctrl.sv
// itlb miss control: single outstanding l2 tlb request, array fill and eviction report
`timescale 1ns/1ns
`include "itlb_params.svh"

module itlb_miss_ctrl (
    input  logic                    CLK,
    input  logic                    nRST,
    // miss from the lookup stage
    input  logic                    miss,
    input  itlb_addr_pkg::asid_t    miss_asid,
    input  itlb_addr_pkg::vpn_t     miss_vpn,
    input  itlb_entry_pkg::index_t  miss_index,
    // victim in the set under lookup
    input  itlb_entry_pkg::way_t    victim_way,
    input  logic                    victim_valid,
    input  itlb_entry_pkg::entry_t  victim_entry,
    input  logic                    fill_pma_fault,
    // l2 tlb request
    output logic                    l2_tlb_req_valid,
    output itlb_addr_pkg::asid_t    l2_tlb_req_asid,
    output itlb_addr_pkg::vpn_t     l2_tlb_req_vpn,
    input  logic                    l2_tlb_req_ready,
    // l2 tlb response
    input  logic                    l2_tlb_resp_valid,
    input  itlb_addr_pkg::pte_t     l2_tlb_resp_pte,
    input  logic                    l2_tlb_resp_access_fault,
    // eviction to l2 tlb
    output logic                    l2_tlb_evict_valid,
    output itlb_addr_pkg::asid_t    l2_tlb_evict_asid,
    output itlb_addr_pkg::vpn_t     l2_tlb_evict_vpn,
    output itlb_addr_pkg::pte_t     l2_tlb_evict_pte,
    // array fill
    output logic                    fill,
    output itlb_entry_pkg::index_t  fill_index,
    output itlb_entry_pkg::way_t    fill_way,
    output itlb_entry_pkg::entry_t  fill_entry
);
    import itlb_addr_pkg::*;
    import itlb_entry_pkg::*;

    miss_state_t state;
    miss_state_t next_state;
    asid_t       asid_q;
    vpn_t        vpn_q;
    index_t      index_q;
    logic        take_miss;

    assign take_miss = (state == MISS_IDLE) & miss;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            state <= MISS_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (take_miss) begin
            asid_q <= miss_asid;
            vpn_q <= miss_vpn;
            index_q <= miss_index;
        end
    end

    // ----------------------------
    // next state
    always_comb begin
        next_state = state;
        case (state)
            MISS_IDLE: begin
                // request already offered this cycle, skip MISS_REQ if taken
                if (miss) begin
                    next_state = l2_tlb_req_ready ? MISS_WAIT : MISS_REQ;
                end
            end
            MISS_REQ: begin
                if (l2_tlb_req_ready) begin
                    next_state = MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                if (l2_tlb_resp_valid) begin
                    next_state = MISS_FILL;
                end
            end
            MISS_FILL: next_state = MISS_IDLE;
            default: next_state = MISS_IDLE;
        endcase
    end

    // ----------------------------
    // request, fill and eviction
    assign l2_tlb_req_valid = take_miss | (state == MISS_REQ);
    assign l2_tlb_req_asid = take_miss ? miss_asid : asid_q;
    assign l2_tlb_req_vpn = take_miss ? miss_vpn : vpn_q;

    assign fill = (state == MISS_WAIT) & l2_tlb_resp_valid;
    assign fill_index = index_q;
    assign fill_way = victim_way;
    assign fill_entry = {1'b1, asid_q, vpn_q, l2_tlb_resp_pte,
        l2_tlb_resp_access_fault | fill_pma_fault};

    assign l2_tlb_evict_valid = fill & victim_valid;
    assign l2_tlb_evict_asid = victim_entry[`ITLB_ENTRY_ASID_LSB +: `ITLB_ASID_WIDTH];
    assign l2_tlb_evict_vpn = victim_entry[`ITLB_ENTRY_VPN_LSB +: `ITLB_VPN_WIDTH];

    // any pte held here has been accessed
    always_comb begin
        l2_tlb_evict_pte = victim_entry[`ITLB_ENTRY_PTE_LSB +: `ITLB_PTE_WIDTH];
        l2_tlb_evict_pte[`ITLB_PTE_A] = 1'b1;
    end

endmodule

//--- source/itlb.sv
// itlb top: hashed set lookup over two stages, response checks and blocking miss path
`timescale 1ns/1ns
`include "itlb_params.svh"

module itlb (
    input  logic                        CLK,
    input  logic                        nRST,
    // core request
    input  logic                        core_req_valid,
    input  itlb_addr_pkg::exec_mode_t   core_req_exec_mode,
    input  logic                        core_req_virtual_mode,
    input  itlb_addr_pkg::asid_t        core_req_asid,
    input  itlb_addr_pkg::vpn_t         core_req_vpn,
    // core response
    output logic                        core_resp_valid,
    output itlb_addr_pkg::ppn_t         core_resp_ppn,
    output logic                        core_resp_page_fault,
    output logic                        core_resp_access_fault,
    // l2 tlb request
    output logic                        l2_tlb_req_valid,
    output itlb_addr_pkg::asid_t        l2_tlb_req_asid,
    output itlb_addr_pkg::vpn_t         l2_tlb_req_vpn,
    input  logic                        l2_tlb_req_ready,
    // l2 tlb response
    input  logic                        l2_tlb_resp_valid,
    input  itlb_addr_pkg::pte_t         l2_tlb_resp_pte,
    input  logic                        l2_tlb_resp_access_fault,
    // eviction to l2 tlb
    output logic                        l2_tlb_evict_valid,
    output itlb_addr_pkg::asid_t        l2_tlb_evict_asid,
    output itlb_addr_pkg::vpn_t         l2_tlb_evict_vpn,
    output itlb_addr_pkg::pte_t         l2_tlb_evict_pte
);
    import itlb_addr_pkg::*;
    import itlb_entry_pkg::*;

    index_t                  read_index;
    // second stage
    logic                    stage_valid;
    logic                    stage_virtual;
    exec_mode_t              stage_exec_mode;
    asid_t                   stage_asid;
    vpn_t                    stage_vpn;
    index_t                  stage_index;
    entry_t [`ITLB_WAYS-1:0] read_entries;
    entry_t [`ITLB_WAYS-1:0] stage_entries;
    plru_t                   read_plru;
    plru_t                   stage_plru;
    logic                    hit;
    logic                    miss;
    way_t                    hit_way;
    way_t                    victim_way;
    logic                    victim_valid;
    plru_t                   plru_out;
    logic                    plru_update;
    // fill and array write
    logic                    fill;
    logic                    fill_pma_fault;
    index_t                  fill_index;
    way_t                    fill_way;
    entry_t                  fill_entry;
    index_t                  write_index;
    // last array write, for the lookup that read at the same edge
    logic                    fwd_entry_valid;
    logic                    fwd_plru_valid;
    index_t                  fwd_index;
    way_t                    fwd_way;
    entry_t                  fwd_entry;
    plru_t                   fwd_plru;

    // ----------------------------
    // first stage
    assign read_index = core_req_vpn[`ITLB_INDEX_WIDTH-1:0]
        ^ core_req_vpn[2*`ITLB_INDEX_WIDTH-1:`ITLB_INDEX_WIDTH]
        ^ core_req_asid[`ITLB_INDEX_WIDTH-1:0]
        ^ core_req_asid[2*`ITLB_INDEX_WIDTH-1:`ITLB_INDEX_WIDTH];

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            stage_valid <= 1'b0;
            fwd_entry_valid <= 1'b0;
            fwd_plru_valid <= 1'b0;
        end else begin
            stage_valid <= core_req_valid;
            fwd_entry_valid <= fill;
            fwd_plru_valid <= plru_update;
        end
    end

    always_ff @(posedge CLK) begin
        if (core_req_valid) begin
            stage_virtual <= core_req_virtual_mode;
            stage_exec_mode <= core_req_exec_mode;
            stage_asid <= core_req_asid;
            stage_vpn <= core_req_vpn;
            stage_index <= read_index;
        end
        fwd_index <= write_index;
        fwd_way <= fill_way;
        fwd_entry <= fill_entry;
        fwd_plru <= plru_out;
    end

    // ----------------------------
    // second stage
    // array read misses a write on the same edge, patch it in here
    always_comb begin
        stage_entries = read_entries;
        stage_plru = read_plru;
        if (fwd_entry_valid && fwd_index == stage_index) begin
            stage_entries[fwd_way] = fwd_entry;
        end
        if (fwd_plru_valid && fwd_index == stage_index) begin
            stage_plru = fwd_plru;
        end
    end

    assign miss = stage_valid & stage_virtual & ~hit;
    assign core_resp_valid = stage_valid & (~stage_virtual | hit);
    // a fill lands in the missing set, tree updates in the looked-up set
    assign write_index = fill ? fill_index : stage_index;

    itlb_array array0 (
        .CLK(CLK),
        .nRST(nRST),
        .read_en(core_req_valid),
        .read_index(read_index),
        .read_entries(read_entries),
        .read_plru(read_plru),
        .write_en(fill),
        .write_index(write_index),
        .write_way(fill_way),
        .write_entry(fill_entry),
        .plru_write_en(plru_update),
        .plru_write(plru_out)
    );

    itlb_way_select way_select0 (
        .stage_valid(stage_valid & stage_virtual),
        .lookup_asid(stage_asid),
        .lookup_vpn(stage_vpn),
        .entries(stage_entries),
        .plru_in(stage_plru),
        .*
    );

    itlb_fault_check fault_check0 (
        .virtual_mode(stage_virtual),
        .exec_mode(stage_exec_mode),
        .lookup_vpn(stage_vpn),
        .hit_entry(stage_entries[hit_way]),
        .fill_pte(l2_tlb_resp_pte),
        .ppn(core_resp_ppn),
        .page_fault(core_resp_page_fault),
        .access_fault(core_resp_access_fault),
        .fill_pma_fault(fill_pma_fault)
    );

    // core re-presents a missing fetch, so the victim comes from the live stage
    itlb_miss_ctrl miss_ctrl0 (
        .miss_asid(stage_asid),
        .miss_vpn(stage_vpn),
        .miss_index(stage_index),
        .victim_entry(stage_entries[victim_way]),
        .*
    );

endmodule

//--- test/tb_clock.sv
// testbench clock and power-on reset, 10 ns period, reset low for the first cycles
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // release just after an edge, like every other input
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
    end

endmodule

//--- test/itlb_tb.sv
// itlb testbench driving directed lookups against an l2 tlb model with a fixed ready delay
`timescale 1ns/1ns
`include "itlb_params.svh"

module itlb_tb;
    import itlb_addr_pkg::*;

    // about 30 lookups of at most 8 cycles each plus reset fit well inside
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int READY_DELAY = 2;
    localparam exec_mode_t SUPER_MODE = 2'b01;

    logic       CLK;
    logic       nRST;
    logic       core_req_valid;
    exec_mode_t core_req_exec_mode;
    logic       core_req_virtual_mode;
    asid_t      core_req_asid;
    vpn_t       core_req_vpn;
    logic       core_resp_valid;
    ppn_t       core_resp_ppn;
    logic       core_resp_page_fault;
    logic       core_resp_access_fault;
    logic       l2_tlb_req_valid;
    asid_t      l2_tlb_req_asid;
    vpn_t       l2_tlb_req_vpn;
    logic       l2_tlb_req_ready;
    logic       l2_tlb_resp_valid;
    pte_t       l2_tlb_resp_pte;
    logic       l2_tlb_resp_access_fault;
    logic       l2_tlb_evict_valid;
    asid_t      l2_tlb_evict_asid;
    vpn_t       l2_tlb_evict_vpn;
    pte_t       l2_tlb_evict_pte;

    // scoreboard state
    string       test_name;
    int          error_count;
    int          check_count;
    int          cycle_count = 0;
    logic [31:0] lcg_state = 32'h223;
    logic        got_missed;
    ppn_t        got_ppn;
    logic        got_pf;
    logic        got_af;
    // what the l2 model answers and what it saw
    pte_t        next_pte;
    logic        next_access_fault;
    int          req_count;
    asid_t       req_asid;
    vpn_t        req_vpn;
    int          evict_count;
    asid_t       evict_asid;
    vpn_t        evict_vpn;
    pte_t        evict_pte;

    tb_clock clock0 (
        .CLK(CLK),
        .nRST(nRST)
    );

    itlb dut0 (.*);

    // ------------------------------
    // helpers
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic ppn_t pte_ppn(input pte_t pte);
        return pte[`ITLB_PTE_PPN_LSB +: `ITLB_PPN_WIDTH];
    endfunction

    // executable user page in dram with the ppn mixed from the vpn
    function automatic pte_t make_pte(input vpn_t vpn);
        logic [31:0] rnd;
        pte_t        pte;
        rnd = next_random();
        pte = '0;
        pte[`ITLB_PTE_PPN_LSB +: `ITLB_PPN_WIDTH] = `ITLB_DRAM_PPN_LO
            | {4'h0, rnd[17:0] ^ vpn[17:0]};
        pte[`ITLB_PTE_V] = 1'b1;
        pte[`ITLB_PTE_R] = 1'b1;
        pte[`ITLB_PTE_X] = 1'b1;
        pte[`ITLB_PTE_U] = 1'b1;
        pte[`ITLB_PTE_A] = 1'b1;
        pte[`ITLB_PTE_W] = rnd[19];
        pte[`ITLB_PTE_G] = rnd[20];
        pte[`ITLB_PTE_D] = rnd[21];
        pte[9:8] = rnd[23:22];
        return pte;
    endfunction

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // re-present the fetch every cycle until it is answered
    task automatic lookup(input asid_t asid, input vpn_t vpn, input logic virt,
                          input exec_mode_t mode);
        core_req_valid = 1'b1;
        core_req_asid = asid;
        core_req_vpn = vpn;
        core_req_virtual_mode = virt;
        core_req_exec_mode = mode;
        got_missed = 1'b0;
        @(posedge CLK);
        #1;
        while (!core_resp_valid) begin
            got_missed = 1'b1;
            @(posedge CLK);
            #1;
        end
        got_ppn = core_resp_ppn;
        got_pf = core_resp_page_fault;
        got_af = core_resp_access_fault;
        core_req_valid = 1'b0;
    endtask

    task automatic check_lookup(input string what, input logic exp_missed, input ppn_t exp_ppn,
                                input logic exp_pf, input logic exp_af);
        compare({what, " missed"}, 32'(exp_missed), 32'(got_missed));
        compare({what, " ppn"}, 32'(exp_ppn), 32'(got_ppn));
        compare({what, " page_fault"}, 32'(exp_pf), 32'(got_pf));
        compare({what, " access_fault"}, 32'(exp_af), 32'(got_af));
    endtask

    // miss that the l2 answers with the given pte
    task automatic fault_case(input string what, input vpn_t vpn, input pte_t pte,
                              input logic l2_fault, input exec_mode_t mode,
                              input logic exp_pf, input logic exp_af);
        next_pte = pte;
        next_access_fault = l2_fault;
        lookup(9'h040, vpn, 1'b1, mode);
        check_lookup(what, 1'b1, pte_ppn(pte), exp_pf, exp_af);
    endtask

    // ------------------------------
    // l2 tlb model
    initial begin
        forever begin
            @(posedge CLK);
            #1;
            if (l2_tlb_req_valid) begin
                repeat (READY_DELAY) begin
                    @(posedge CLK);
                    #1;
                end
                if (!l2_tlb_req_valid) begin
                    error_count++;
                    $display("l2 request was withdrawn before it was accepted");
                end
                l2_tlb_req_ready = 1'b1;
                @(posedge CLK);
                #1;
                l2_tlb_req_ready = 1'b0;
                l2_tlb_resp_valid = 1'b1;
                l2_tlb_resp_pte = next_pte;
                l2_tlb_resp_access_fault = next_access_fault;
                @(posedge CLK);
                #1;
                l2_tlb_resp_valid = 1'b0;
            end
        end
    end

    // handshakes seen mid-cycle
    always @(negedge CLK) begin
        if (l2_tlb_req_valid && l2_tlb_req_ready) begin
            req_count++;
            req_asid = l2_tlb_req_asid;
            req_vpn = l2_tlb_req_vpn;
        end
        if (l2_tlb_evict_valid) begin
            evict_count++;
            evict_asid = l2_tlb_evict_asid;
            evict_vpn = l2_tlb_evict_vpn;
            evict_pte = l2_tlb_evict_pte;
        end
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // ------------------------------
    // tests
    task automatic reset_bare_test();
        int start_reqs;
        test_name = "reset_bare";
        start_reqs = req_count;
        compare("core_resp_valid", 32'(0), 32'(core_resp_valid));
        compare("l2_tlb_req_valid", 32'(0), 32'(l2_tlb_req_valid));
        compare("l2_tlb_evict_valid", 32'(0), 32'(l2_tlb_evict_valid));
        // dram, rom, hole, above dram
        lookup(9'h001, 20'h80005, 1'b0, 2'b11);
        check_lookup("dram", 1'b0, 22'h380005, 1'b0, 1'b0);
        lookup(9'h001, 20'h00015, 1'b0, `ITLB_U_MODE);
        check_lookup("rom", 1'b0, 22'h000015, 1'b0, 1'b0);
        lookup(9'h001, 20'h12345, 1'b0, 2'b11);
        check_lookup("hole", 1'b0, 22'h012345, 1'b0, 1'b1);
        lookup(9'h001, 20'hC0000, 1'b0, 2'b11);
        check_lookup("high", 1'b0, 22'h3C0000, 1'b0, 1'b1);
        compare("l2 requests", 32'(start_reqs), 32'(req_count));
    endtask

    task automatic first_miss_test();
        int start_reqs;
        test_name = "first_miss";
        start_reqs = req_count;
        next_pte = make_pte(20'h12340);
        next_access_fault = 1'b0;
        lookup(9'h011, 20'h12340, 1'b1, SUPER_MODE);
        check_lookup("miss", 1'b1, pte_ppn(next_pte), 1'b0, 1'b0);
        compare("l2 requests", 32'(start_reqs + 1), 32'(req_count));
        compare("l2 asid", 32'(9'h011), 32'(req_asid));
        compare("l2 vpn", 32'(20'h12340), 32'(req_vpn));
        lookup(9'h011, 20'h12340, 1'b1, SUPER_MODE);
        check_lookup("repeat", 1'b0, pte_ppn(next_pte), 1'b0, 1'b0);
        compare("l2 requests after hit", 32'(start_reqs + 1), 32'(req_count));
    endtask

    // vpn low nibbles keep these entries out of set 3
    task automatic page_fault_test();
        pte_t pte;
        test_name = "page_fault";
        pte = make_pte(20'h31001);
        pte[`ITLB_PTE_V] = 1'b0;
        fault_case("v clear", 20'h31001, pte, 1'b0, SUPER_MODE, 1'b1, 1'b0);
        pte = make_pte(20'h31002);
        pte[`ITLB_PTE_X] = 1'b0;
        fault_case("x clear", 20'h31002, pte, 1'b0, SUPER_MODE, 1'b1, 1'b0);
        pte = make_pte(20'h31004);
        pte[`ITLB_PTE_R] = 1'b0;
        pte[`ITLB_PTE_W] = 1'b1;
        fault_case("w without r", 20'h31004, pte, 1'b0, SUPER_MODE, 1'b1, 1'b0);
        pte = make_pte(20'h31005);
        pte[`ITLB_PTE_U] = 1'b0;
        fault_case("u clear user", 20'h31005, pte, 1'b0, `ITLB_U_MODE, 1'b1, 1'b0);
        // same page from supervisor mode is fine
        lookup(9'h040, 20'h31005, 1'b1, SUPER_MODE);
        check_lookup("u clear super", 1'b0, pte_ppn(pte), 1'b0, 1'b0);
        pte = make_pte(20'h31008);
        fault_case("clean", 20'h31008, pte, 1'b0, `ITLB_U_MODE, 1'b0, 1'b0);
        pte = make_pte(20'h3100A);
        fault_case("l2 fault", 20'h3100A, pte, 1'b1, SUPER_MODE, 1'b0, 1'b1);
        pte = make_pte(20'h3100F);
        pte[`ITLB_PTE_PPN_LSB +: `ITLB_PPN_WIDTH] = 22'h100000;
        fault_case("outside map", 20'h3100F, pte, 1'b0, SUPER_MODE, 1'b0, 1'b1);
    endtask

    // both asids hash with the vpn into set 2 where only the asid compare separates them
    task automatic asid_test();
        pte_t pte_a;
        pte_t pte_b;
        test_name = "asid";
        pte_a = make_pte(20'h70002);
        pte_b = make_pte(20'h70002);
        next_access_fault = 1'b0;
        next_pte = pte_a;
        lookup(9'h010, 20'h70002, 1'b1, SUPER_MODE);
        check_lookup("first asid", 1'b1, pte_ppn(pte_a), 1'b0, 1'b0);
        next_pte = pte_b;
        lookup(9'h020, 20'h70002, 1'b1, SUPER_MODE);
        check_lookup("second asid", 1'b1, pte_ppn(pte_b), 1'b0, 1'b0);
        lookup(9'h010, 20'h70002, 1'b1, SUPER_MODE);
        check_lookup("first again", 1'b0, pte_ppn(pte_a), 1'b0, 1'b0);
        lookup(9'h020, 20'h70002, 1'b1, SUPER_MODE);
        check_lookup("second again", 1'b0, pte_ppn(pte_b), 1'b0, 1'b0);
    endtask

    // low vpn nibble 3 with asid nibble 0 hashes every page into set 3
    task automatic eviction_test();
        pte_t ptes [5];
        vpn_t vpns [5];
        pte_t expected_evict;
        int   start_evicts;
        test_name = "eviction";
        start_evicts = evict_count;
        next_access_fault = 1'b0;
        for (int i = 0; i < 5; i++) begin
            vpns[i] = 20'h50003 + vpn_t'(i) * 20'h10;
            ptes[i] = make_pte(vpns[i]);
            if (i == 0) begin
                ptes[i][`ITLB_PTE_A] = 1'b0;
            end
            next_pte = ptes[i];
            lookup(9'h030, vpns[i], 1'b1, SUPER_MODE);
            check_lookup("fill", 1'b1, pte_ppn(ptes[i]), 1'b0, 1'b0);
            compare("evictions", 32'(start_evicts + ((i == 4) ? 1 : 0)), 32'(evict_count));
        end
        expected_evict = ptes[0];
        expected_evict[`ITLB_PTE_A] = 1'b1;
        compare("evict asid", 32'(9'h030), 32'(evict_asid));
        compare("evict vpn", 32'(vpns[0]), 32'(evict_vpn));
        compare("evict pte", expected_evict, evict_pte);
        for (int i = 1; i < 5; i++) begin
            lookup(9'h030, vpns[i], 1'b1, SUPER_MODE);
            check_lookup("kept", 1'b0, pte_ppn(ptes[i]), 1'b0, 1'b0);
        end
        next_pte = ptes[0];
        lookup(9'h030, vpns[0], 1'b1, SUPER_MODE);
        check_lookup("evicted", 1'b1, pte_ppn(ptes[0]), 1'b0, 1'b0);
        // hits on ways 1, 2, 3 and 0 leave the tree pointing at way 2
        compare("evictions after refill", 32'(start_evicts + 2), 32'(evict_count));
        compare("second evict vpn", 32'(vpns[2]), 32'(evict_vpn));
    endtask

    // ------------------------------
    // main sequence
    initial begin
        core_req_valid = 1'b0;
        core_req_exec_mode = SUPER_MODE;
        core_req_virtual_mode = 1'b0;
        core_req_asid = '0;
        core_req_vpn = '0;
        l2_tlb_req_ready = 1'b0;
        l2_tlb_resp_valid = 1'b0;
        l2_tlb_resp_pte = '0;
        l2_tlb_resp_access_fault = 1'b0;
        next_pte = '0;
        next_access_fault = 1'b0;
        error_count = 0;
        check_count = 0;
        req_count = 0;
        evict_count = 0;
        wait (nRST === 1'b1);
        reset_bare_test();
        first_miss_test();
        page_fault_test();
        asid_test();
        eviction_test();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
source/itlb_addr_pkg.sv
source/itlb_entry_pkg.sv
source/itlb_array.sv
source/itlb_way_select.sv
source/itlb_fault_check.sv
source/itlb_miss_ctrl.sv
source/itlb.sv
test/tb_clock.sv
test/itlb_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f files.f --top-module itlb_tb -o itlb_sim
sim_output=$(./obj_dir/itlb_sim)
echo "$sim_output"
if echo "$sim_output" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi
